//--- rr_head_if.sv
`include "rr_stripe_cfg.svh"

interface rr_head_if;
   import rr_stripe_pkg::*;

   // input side heads, position 0 is the channel at the input pointer
   rr_meet_vec_t valid_head;
   rr_word_t data_head [`RR_MEET-1:0];

   // output side heads, position 0 is the channel at the output pointer
   rr_meet_vec_t ready_head;

   // leading run of matched positions
   rr_meet_vec_t go;
   // length of that run
   rr_go_cnt_t go_cnt;

   // input rotator
   modport src (
      output valid_head,
      output data_head,
      input go,
      input go_cnt
   );

   // output rotator
   modport dst (
      output ready_head,
      input data_head,
      input go,
      input go_cnt
   );

   // matcher
   modport match (input valid_head, input ready_head, output go, output go_cnt);

endinterface

//--- rr_stripe.f
+incdir+.
rr_stripe_pkg.sv
rr_head_if.sv
rr_stripe_input.sv
rr_stripe_middle.sv
rr_stripe_output.sv
rr_stripe_top.sv
tb_rr_stripe_assertions.sv
tb_rr_stripe_checker.sv
tb_rr_stripe.sv

//--- rr_stripe_cfg.svh
`ifndef RR_STRIPE_CFG_SVH
`define RR_STRIPE_CFG_SVH

// payload width of one word
`define RR_WIDTH 16

// channel counts, fixed at build time
`define RR_NUM_IN 4
`define RR_NUM_OUT 3

// most words that can cross in one cycle
`define RR_MEET ((`RR_NUM_IN < `RR_NUM_OUT) ? `RR_NUM_IN : `RR_NUM_OUT)

`endif

//--- rr_stripe_input.sv
`include "rr_stripe_cfg.svh"

module rr_stripe_input (
   input  logic clk,
   input  logic reset_i,
   // input fifo heads
   input  logic [`RR_NUM_IN-1:0] valid_i,
   input  rr_stripe_pkg::rr_word_t data_i [`RR_NUM_IN-1:0],
   // same cycle take pulse per channel
   output logic [`RR_NUM_IN-1:0] yumi_o,
   // toward the matcher and output rotator
   rr_head_if.src head
);
   import rr_stripe_pkg::*;

   // channel holding the oldest unread word
   rr_in_ptr_t ptr_r;
   rr_in_ptr_t ptr_next;

   // channel index behind each head position
   rr_in_ptr_t chan_idx [`RR_MEET-1:0];

   // position k maps to channel (ptr + k) mod num_in
   always_comb
   begin
      for (int k = 0; k < `RR_MEET; k++)
      begin
         chan_idx[k] = rr_in_ptr_t'(rr_wrap_add(int'(ptr_r), k, `RR_NUM_IN));
      end
   end

   // present valids and words in pointer order
   always_comb
   begin
      for (int k = 0; k < `RR_MEET; k++)
      begin
         head.valid_head[k] = valid_i[chan_idx[k]];
         head.data_head[k] = data_i[chan_idx[k]];
      end
   end

   // map go back through the same rotation
   // go already implies valid at that position
   always_comb
   begin
      yumi_o = '0;
      for (int k = 0; k < `RR_MEET; k++)
      begin
         if (head.go[k])
         begin
            yumi_o[chan_idx[k]] = 1'b1;
         end
      end
   end

   // advance past every word taken this cycle
   // go_cnt never exceeds num_in, so one wrap suffices
   assign ptr_next = rr_in_ptr_t'(rr_wrap_add(int'(ptr_r), int'(head.go_cnt), `RR_NUM_IN));

   always_ff @(posedge clk)
   begin
      if (reset_i)
      begin
         ptr_r <= '0;
      end
      else
      begin
         ptr_r <= ptr_next;
      end
   end

endmodule

//--- rr_stripe_middle.sv
`include "rr_stripe_cfg.svh"

module rr_stripe_middle (
   // heads from both rotators, go back to both
   rr_head_if.match head
);
   import rr_stripe_pkg::*;

   // positions with a word waiting and room for it
   rr_meet_vec_t pair_ok;
   // leading run of pair_ok
   rr_meet_vec_t run;
   rr_go_cnt_t run_cnt;

   assign pair_ok = head.valid_head & head.ready_head;

   // any gap kills every later position, keeps strict order
   always_comb
   begin
      run[0] = pair_ok[0];
      for (int k = 1; k < `RR_MEET; k++)
      begin
         run[k] = run[k-1] & pair_ok[k];
      end
   end

   // run is contiguous from bit 0, so a popcount is its length
   always_comb
   begin
      run_cnt = '0;
      for (int k = 0; k < `RR_MEET; k++)
      begin
         if (run[k])
         begin
            run_cnt = run_cnt + rr_go_cnt_t'(1);
         end
      end
   end

   // purely combinational, no state here
   assign head.go = run;
   assign head.go_cnt = run_cnt;

endmodule

//--- rr_stripe_output.sv
`include "rr_stripe_cfg.svh"

module rr_stripe_output (
   input  logic clk,
   input  logic reset_i,
   // output fifo tails
   input  logic [`RR_NUM_OUT-1:0] ready_i,
   output logic [`RR_NUM_OUT-1:0] valid_o,
   output rr_stripe_pkg::rr_word_t data_o [`RR_NUM_OUT-1:0],
   // from the input rotator and matcher
   rr_head_if.dst head
);
   import rr_stripe_pkg::*;

   // channel that takes the next word
   rr_out_ptr_t ptr_r;
   rr_out_ptr_t ptr_next;

   // channel index behind each head position
   rr_out_ptr_t chan_idx [`RR_MEET-1:0];

   // position k maps to channel (ptr + k) mod num_out
   always_comb
   begin
      for (int k = 0; k < `RR_MEET; k++)
      begin
         chan_idx[k] = rr_out_ptr_t'(rr_wrap_add(int'(ptr_r), k, `RR_NUM_OUT));
      end
   end

   // readies in pointer order for the matcher
   always_comb
   begin
      for (int k = 0; k < `RR_MEET; k++)
      begin
         head.ready_head[k] = ready_i[chan_idx[k]];
      end
   end

   // steer matched words to their channels
   // idle lanes drive zero
   always_comb
   begin
      valid_o = '0;
      for (int c = 0; c < `RR_NUM_OUT; c++)
      begin
         data_o[c] = '0;
      end
      for (int k = 0; k < `RR_MEET; k++)
      begin
         // go[k] implies ready at this channel
         if (head.go[k])
         begin
            valid_o[chan_idx[k]] = 1'b1;
            data_o[chan_idx[k]] = head.data_head[k];
         end
      end
   end

   // move past every channel written this cycle
   assign ptr_next = rr_out_ptr_t'(rr_wrap_add(int'(ptr_r), int'(head.go_cnt), `RR_NUM_OUT));

   always_ff @(posedge clk)
   begin
      if (reset_i)
      begin
         ptr_r <= '0;
      end
      else
      begin
         ptr_r <= ptr_next;
      end
   end

endmodule

//--- rr_stripe_pkg.sv
package rr_stripe_pkg;

`include "rr_stripe_cfg.svh"

   // pointer widths, at least one bit even for a single channel
   localparam int RR_IN_PTR_W = (`RR_NUM_IN > 1) ? $clog2(`RR_NUM_IN) : 1;
   localparam int RR_OUT_PTR_W = (`RR_NUM_OUT > 1) ? $clog2(`RR_NUM_OUT) : 1;
   // count must hold 0 .. RR_MEET inclusive
   localparam int RR_CNT_W = $clog2(`RR_MEET + 1);

   // one data word
   typedef logic [`RR_WIDTH-1:0] rr_word_t;

   // one bit per head position
   typedef logic [`RR_MEET-1:0] rr_meet_vec_t;

   // words moving this cycle
   typedef logic [RR_CNT_W-1:0] rr_go_cnt_t;

   // head pointers
   typedef logic [RR_IN_PTR_W-1:0] rr_in_ptr_t;
   typedef logic [RR_OUT_PTR_W-1:0] rr_out_ptr_t;

   // modular add, valid while base and step are both below modulus
   // so one subtract is enough
   function automatic int rr_wrap_add(input int base, input int step, input int modulus);
      int sum;
      sum = base + step;
      if (sum >= modulus)
      begin
         sum = sum - modulus;
      end
      return sum;
   endfunction

endpackage

//--- rr_stripe_top.sv
`include "rr_stripe_cfg.svh"

module rr_stripe_top (
   input  logic clk,
   input  logic reset_i,
   // input side, valid level and yumi pulse
   input  logic [`RR_NUM_IN-1:0] valid_i,
   input  rr_stripe_pkg::rr_word_t data_i [`RR_NUM_IN-1:0],
   output logic [`RR_NUM_IN-1:0] yumi_o,
   // output side, valid only where ready
   input  logic [`RR_NUM_OUT-1:0] ready_i,
   output logic [`RR_NUM_OUT-1:0] valid_o,
   output rr_stripe_pkg::rr_word_t data_o [`RR_NUM_OUT-1:0]
);

   // head signals shared by the three blocks
   rr_head_if head_if ();

   // owns the input pointer, gathers input heads
   rr_stripe_input input_inst (
      .clk     (clk),
      .reset_i (reset_i),
      .valid_i (valid_i),
      .data_i  (data_i),
      .yumi_o  (yumi_o),
      .head    (head_if.src)
   );

   // decides how many words cross this cycle
   rr_stripe_middle middle_inst (
      .head (head_if.match)
   );

   // owns the output pointer, scatters words to output channels
   rr_stripe_output output_inst (
      .clk     (clk),
      .reset_i (reset_i),
      .ready_i (ready_i),
      .valid_o (valid_o),
      .data_o  (data_o),
      .head    (head_if.dst)
   );

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the crossbar testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
   -f rr_stripe.f --top-module tb_rr_stripe

# verdict comes from the printed output, not the exit status
sim_out=$(./obj_dir/Vtb_rr_stripe 2>&1 || true)
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -q "TB PASSED"; then
   exit 0
fi
exit 1

//--- tb_rr_stripe.sv
`include "rr_stripe_cfg.svh"

module tb_rr_stripe;
   timeunit 1ns;
   timeprecision 100ps;
   import rr_stripe_pkg::*;

   typedef logic [`RR_NUM_IN-1:0] in_mask_t;
   typedef logic [`RR_NUM_OUT-1:0] out_mask_t;

   localparam int DRAIN_TIMEOUT = 300;

   logic clk;
   logic reset_i;
   in_mask_t valid_i;
   rr_word_t data_i [`RR_NUM_IN-1:0];
   in_mask_t yumi_o;
   out_mask_t ready_i;
   out_mask_t valid_o;
   rr_word_t data_o [`RR_NUM_OUT-1:0];
   logic end_check;
   int checker_errors;
   int model_fifo_cnt;
   int tb_errors = 0;
   int assert_errors;
   int drain_cycles;
   // yumi seen before the coming edge
   in_mask_t taken = '0;

   // pending words per input channel, front is the FIFO head
   rr_word_t chan_q [`RR_NUM_IN-1:0][$];

   always #2 clk = ~clk;

   rr_stripe_top rr_stripe_top_inst (
      .clk     (clk),
      .reset_i (reset_i),
      .valid_i (valid_i),
      .data_i  (data_i),
      .yumi_o  (yumi_o),
      .ready_i (ready_i),
      .valid_o (valid_o),
      .data_o  (data_o)
   );

   tb_rr_stripe_checker checker_inst (
      .clk         (clk),
      .reset_i     (reset_i),
      .valid_i     (valid_i),
      .data_i      (data_i),
      .yumi_o      (yumi_o),
      .ready_i     (ready_i),
      .valid_o     (valid_o),
      .data_o      (data_o),
      .end_check_i (end_check),
      .err_cnt_o   (checker_errors),
      .fifo_cnt_o  (model_fifo_cnt)
   );

   task automatic fill_queues(input int words);
      for (int c = 0; c < `RR_NUM_IN; c++)
      begin
         for (int n = 0; n < words; n++)
         begin
            chan_q[c].push_back(rr_word_t'($urandom));
         end
      end
   endtask

   function automatic bit queues_pending();
      bit pending;
      pending = 1'b0;
      for (int c = 0; c < `RR_NUM_IN; c++)
      begin
         if (chan_q[c].size() != 0)
         begin
            pending = 1'b1;
         end
      end
      return pending;
   endfunction

   // valid only where a word waits and the lane is enabled
   task automatic drive_inputs(input in_mask_t en, input out_mask_t rdy);
      for (int c = 0; c < `RR_NUM_IN; c++)
      begin
         if (en[c] && chan_q[c].size() != 0)
         begin
            valid_i[c] = 1'b1;
            data_i[c] = chan_q[c][0];
         end
         else
         begin
            valid_i[c] = 1'b0;
            // junk that the DUT must ignore
            data_i[c] = rr_word_t'($urandom);
         end
      end
      ready_i = rdy;
   endtask

   // one clock: pop what was taken, drive, then sample yumi mid cycle
   task automatic step(input in_mask_t en, input out_mask_t rdy);
      @(posedge clk);
      #1;
      for (int c = 0; c < `RR_NUM_IN; c++)
      begin
         if (taken[c])
         begin
            void'(chan_q[c].pop_front());
         end
      end
      drive_inputs(en, rdy);
      @(negedge clk);
      taken = yumi_o;
   endtask

   initial
   begin
      void'($urandom(32'h7aaa));
      clk = 1'b0;
      reset_i = 1'b1;
      valid_i = '0;
      ready_i = '0;
      end_check = 1'b0;
      for (int c = 0; c < `RR_NUM_IN; c++)
      begin
         data_i[c] = '0;
      end
      repeat (8) @(posedge clk);
      #1;
      reset_i = 1'b0;
      // idle right after reset
      repeat (2) step('0, out_mask_t'($urandom));
      fill_queues(40);
      // mixed traffic with ordering gaps
      repeat (200) step(in_mask_t'($urandom), out_mask_t'($urandom));
      // full throughput
      fill_queues(10);
      repeat (25) step('1, '1);
      // heavy back-pressure, sparse readies
      fill_queues(20);
      repeat (150) step(in_mask_t'($urandom), out_mask_t'($urandom & $urandom));
      fill_queues(10);
      repeat (25) step('1, '1);
      drain_cycles = 0;
      while ((queues_pending() || model_fifo_cnt != 0) && drain_cycles < DRAIN_TIMEOUT)
      begin
         step('1, '1);
         drain_cycles++;
      end
      if (queues_pending() || model_fifo_cnt != 0)
      begin
         $display("timeout: words still queued after %0d drain cycles", DRAIN_TIMEOUT);
         tb_errors++;
      end
      end_check = 1'b1;
      repeat (2) @(negedge clk);
      #1;
      assert_errors = rr_stripe_top_inst.assertions_inst.fail_cnt;
      $display("errors: checker %0d, testbench %0d, assertions %0d", checker_errors,
               tb_errors, assert_errors);
      if (checker_errors == 0 && tb_errors == 0 && assert_errors == 0)
      begin
         $display("TB PASSED");
      end
      else
      begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

//--- tb_rr_stripe_assertions.sv
`include "rr_stripe_cfg.svh"

module tb_rr_stripe_assertions (
   input logic clk,
   input logic reset_i,
   input logic [`RR_NUM_IN-1:0] valid_i,
   input logic [`RR_NUM_IN-1:0] yumi_o,
   input logic [`RR_NUM_OUT-1:0] ready_i,
   input logic [`RR_NUM_OUT-1:0] valid_o
);
   timeunit 1ns;
   timeprecision 100ps;

   // count of failed properties
   int fail_cnt = 0;

   // a take needs a word behind it
   yumi_needs_valid: assert property (@(posedge clk) disable iff (reset_i)
      (yumi_o & ~valid_i) == '0)
      else
      begin
         $error("yumi_o set on a channel without valid_i");
         fail_cnt++;
      end

   // a write needs room behind it
   valid_needs_ready: assert property (@(posedge clk) disable iff (reset_i)
      (valid_o & ~ready_i) == '0)
      else
      begin
         $error("valid_o set on a channel without ready_i");
         fail_cnt++;
      end

   // words in equal words out, nothing stored inside
   counts_match: assert property (@(posedge clk) disable iff (reset_i)
      $countones(yumi_o) == $countones(valid_o))
      else
      begin
         $error("yumi_o and valid_o counts differ");
         fail_cnt++;
      end

endmodule

bind rr_stripe_top tb_rr_stripe_assertions assertions_inst (
   .clk     (clk),
   .reset_i (reset_i),
   .valid_i (valid_i),
   .yumi_o  (yumi_o),
   .ready_i (ready_i),
   .valid_o (valid_o)
);

//--- tb_rr_stripe_checker.sv
`include "rr_stripe_cfg.svh"

module tb_rr_stripe_checker (
   input  logic clk,
   input  logic reset_i,
   // DUT input side, watched only
   input  logic [`RR_NUM_IN-1:0] valid_i,
   input  rr_stripe_pkg::rr_word_t data_i [`RR_NUM_IN-1:0],
   input  logic [`RR_NUM_IN-1:0] yumi_o,
   // DUT output side, watched only
   input  logic [`RR_NUM_OUT-1:0] ready_i,
   input  logic [`RR_NUM_OUT-1:0] valid_o,
   input  rr_stripe_pkg::rr_word_t data_o [`RR_NUM_OUT-1:0],
   // closing checks once traffic has stopped
   input  logic end_check_i,
   output int err_cnt_o,
   output int fifo_cnt_o
);
   timeunit 1ns;
   timeprecision 100ps;
   import rr_stripe_pkg::*;

   // model pointers, same meaning as in the DUT
   rr_in_ptr_t in_ptr = '0;
   rr_out_ptr_t out_ptr = '0;
   // accepted words not yet seen on an output
   rr_word_t word_fifo [$];
   // cycles that moved the widest possible run
   int full_cycles = 0;
   int err_cnt = 0;
   int fifo_cnt = 0;
   bit end_done = 1'b0;

   assign err_cnt_o = err_cnt;
   assign fifo_cnt_o = fifo_cnt;

   task automatic report_mismatch(input string name, input logic [31:0] exp_val,
                                  input logic [31:0] act_val);
      $display("ERROR %s expected 0x%0h actual 0x%0h", name, exp_val, act_val);
      err_cnt++;
   endtask

   task automatic check_cycle();
      logic [`RR_NUM_IN-1:0] exp_yumi;
      logic [`RR_NUM_OUT-1:0] exp_valid;
      int run_len;
      bit stopped;
      rr_in_ptr_t in_ch;
      rr_out_ptr_t out_ch;
      rr_word_t exp_word;
      exp_yumi = '0;
      exp_valid = '0;
      run_len = 0;
      stopped = 1'b0;
      // leading run of word-and-room pairs from both pointers
      while (!stopped && run_len < `RR_MEET)
      begin
         in_ch = rr_in_ptr_t'((int'(in_ptr) + run_len) % `RR_NUM_IN);
         out_ch = rr_out_ptr_t'((int'(out_ptr) + run_len) % `RR_NUM_OUT);
         if (valid_i[in_ch] && ready_i[out_ch])
         begin
            exp_yumi[in_ch] = 1'b1;
            exp_valid[out_ch] = 1'b1;
            // accepted in yumi order
            word_fifo.push_back(data_i[in_ch]);
            run_len++;
         end
         else
         begin
            stopped = 1'b1;
         end
      end
      if (yumi_o !== exp_yumi)
      begin
         report_mismatch("yumi_o", 32'(exp_yumi), 32'(yumi_o));
      end
      if (valid_o !== exp_valid)
      begin
         report_mismatch("valid_o", 32'(exp_valid), 32'(valid_o));
      end
      // words leave in the order they came in, one per written lane from the pointer
      for (int k = 0; k < `RR_NUM_OUT; k++)
      begin
         out_ch = rr_out_ptr_t'((int'(out_ptr) + k) % `RR_NUM_OUT);
         if (valid_o[out_ch] === 1'b1 && word_fifo.size() != 0)
         begin
            exp_word = word_fifo.pop_front();
            if (data_o[out_ch] !== exp_word)
            begin
               report_mismatch($sformatf("data_o[%0d]", out_ch), 32'(exp_word),
                               32'(data_o[out_ch]));
            end
         end
      end
      // idle lanes stay at zero
      for (int c = 0; c < `RR_NUM_OUT; c++)
      begin
         if (!exp_valid[c] && data_o[c] !== '0)
         begin
            report_mismatch($sformatf("data_o[%0d]", c), 32'h0, 32'(data_o[c]));
         end
      end
      if (run_len == `RR_MEET)
      begin
         full_cycles++;
      end
      in_ptr = rr_in_ptr_t'((int'(in_ptr) + run_len) % `RR_NUM_IN);
      out_ptr = rr_out_ptr_t'((int'(out_ptr) + run_len) % `RR_NUM_OUT);
   endtask

   // inputs move 1 ns after the rising edge, so the falling edge sees settled values
   always @(negedge clk)
   begin
      if (reset_i)
      begin
         // no valid inputs during reset, so nothing may move
         if (yumi_o !== '0)
         begin
            report_mismatch("yumi_o", 32'h0, 32'(yumi_o));
         end
         if (valid_o !== '0)
         begin
            report_mismatch("valid_o", 32'h0, 32'(valid_o));
         end
         in_ptr = '0;
         out_ptr = '0;
         word_fifo.delete();
      end
      else
      begin
         check_cycle();
      end
      fifo_cnt = word_fifo.size();
      if (end_check_i && !end_done)
      begin
         end_done = 1'b1;
         if (word_fifo.size() != 0)
         begin
            $display("words accepted but never delivered: %0d", word_fifo.size());
            err_cnt++;
         end
         if (full_cycles == 0)
         begin
            $display("no cycle moved the full run of words");
            err_cnt++;
         end
      end
   end

endmodule
